//--- Bender.yml
package:
  name: robocup_motor_fpga

sources:
  - motor_cfg_pkg.sv
  - host_proto_pkg.sv
  - pin_sync.sv
  - spi_byte_slave.sv
  - host_cmd_engine.sv
  - motor_watchdog.sv
  - quad_encoder_counter.sv
  - bldc_commutator.sv
  - robocup_top.sv
  - target: test
    files:
      - robocup_tb.sv

//--- bldc_commutator.sv
// Six step commutation for one motor with high side PWM and all gates off for halls 000 and 111
`timescale 1ns/1ps
`default_nettype none

module bldc_commutator import motor_cfg_pkg::*; (
    input  wire        sysclk,
    input  wire        watchdog_timer_reset_flag,
    input  wire hall_t hall_i,
    input  wire duty_t duty_i,
    input  wire        en_i,
    output phase_t     phase_o,
    output logic       hall_ok_o
);

    duty_t pwm_cnt;
    logic  pwm_on;

    // Free running PWM frame
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            pwm_cnt <= '0;
        end else if (pwm_cnt == duty_t'(PWM_PERIOD - 1)) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    assign pwm_on    = pwm_cnt < duty_i;
    // All zeros or all ones means a missing or shorted sensor
    assign hall_ok_o = (hall_i != 3'b000) && (hall_i != 3'b111);

    // Source high side chops while the sink low side stays on
    always_comb begin
        phase_o = '0;
        case (hall_i)
            3'b101: begin
                phase_o.ah = pwm_on;
                phase_o.bl = 1'b1;
            end
            3'b100: begin
                phase_o.ah = pwm_on;
                phase_o.cl = 1'b1;
            end
            3'b110: begin
                phase_o.bh = pwm_on;
                phase_o.cl = 1'b1;
            end
            3'b010: begin
                phase_o.bh = pwm_on;
                phase_o.al = 1'b1;
            end
            3'b011: begin
                phase_o.ch = pwm_on;
                phase_o.al = 1'b1;
            end
            3'b001: begin
                phase_o.ch = pwm_on;
                phase_o.bl = 1'b1;
            end
            default: phase_o = '0;
        endcase
        if (!en_i) begin
            phase_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- host_cmd_engine.sv
// Host command decoder and motor registers where a request acts only at chip select release
`timescale 1ns/1ps
`default_nettype none

module host_cmd_engine import motor_cfg_pkg::*, host_proto_pkg::*; (
    input  wire                              sysclk,
    input  wire                              watchdog_timer_reset_flag,
    input  wire spi_byte_t                   rx_byte_i,
    input  wire                              byte_done_i,
    input  wire                              start_i,
    input  wire                              end_i,
    input  wire enc_count_t [NUM_MOTORS-1:0] enc_count_i,
    input  wire [WDT_COUNT_WIDTH-1:0]        wdt_count_i,
    input  wire                              wdt_trip_i,
    input  wire [NUM_MOTORS-1:0]             hall_ok_i,
    output spi_byte_t                        tx_byte_o,
    output duty_t      [NUM_MOTORS-1:0]      duty_o,
    output logic                             motors_en_o,
    output logic                             clear_o
);

    logic [BYTE_CNT_WIDTH-1:0] byte_cnt;
    logic                      wdt_tripped_q;
    spi_byte_t                 req_buf [RES_BUF_LEN];
    spi_byte_t                 res_buf [1:RES_BUF_LEN-1];
    status_t                   status;
    cmd_rw_e                   rx_rw;
    cmd_op_e                   rx_op;
    cmd_rw_e                   req_rw;
    cmd_op_e                   req_op;
    logic                      cmd_done;

    // Command arriving now and command stored for the end of transfer
    assign rx_rw    = cmd_rw_e'(rx_byte_i[SPI_BYTE_WIDTH-1]);
    assign rx_op    = cmd_op_e'(rx_byte_i[SPI_BYTE_WIDTH-2:0]);
    assign req_rw   = cmd_rw_e'(req_buf[0][SPI_BYTE_WIDTH-1]);
    assign req_op   = cmd_op_e'(req_buf[0][SPI_BYTE_WIDTH-2:0]);
    assign cmd_done = byte_done_i && (byte_cnt == '0);

    assign status = '{
        motors_en:   motors_en_o,
        wdt_tripped: wdt_tripped_q,
        zero:        2'b00,
        hall_ok:     hall_ok_i
    };

    // Position 0 is always the live status, also on the start cycle itself
    always_comb begin
        if (start_i || byte_cnt == '0) begin
            tx_byte_o = status;
        end else if (byte_cnt < RES_BUF_LEN) begin
            tx_byte_o = res_buf[byte_cnt];
        end else begin
            tx_byte_o = FILL_BYTE;
        end
    end

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            byte_cnt      <= '0;
            duty_o        <= '0;
            motors_en_o   <= 1'b0;
            wdt_tripped_q <= 1'b0;
            clear_o       <= 1'b0;
        end else begin
            clear_o <= 1'b0;
            if (start_i) begin
                byte_cnt <= '0;
            end else if (byte_done_i && byte_cnt < RES_BUF_LEN) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            // Counts are latched on the same edge, cleared the cycle after
            if (cmd_done && rx_rw == CMD_READ && rx_op == CMD_UPDATE_MTRS) begin
                clear_o <= 1'b1;
            end
            // Watchdog expiry wins over any host request
            if (wdt_trip_i) begin
                motors_en_o   <= 1'b0;
                wdt_tripped_q <= 1'b1;
            end else if (end_i) begin
                if (req_rw == CMD_READ && req_op == CMD_UPDATE_MTRS
                    && byte_cnt == 2 * NUM_MOTORS + 1) begin
                    // Duties arrive low byte first per motor
                    for (int j = 0; j < NUM_MOTORS; j++) begin
                        duty_o[j] <= {req_buf[2*j+2][DUTY_WIDTH-SPI_BYTE_WIDTH-1:0],
                                      req_buf[2*j+1]};
                    end
                    motors_en_o   <= 1'b1;
                    wdt_tripped_q <= 1'b0;
                end else if (req_op == CMD_TOGGLE_MOTOR_EN && byte_cnt == 2) begin
                    motors_en_o <= (req_rw == CMD_READ);
                end
            end
        end
    end

    // Buffers hold payload only
    always_ff @(posedge sysclk) begin
        if (byte_done_i && byte_cnt < RES_BUF_LEN) begin
            req_buf[byte_cnt] <= rx_byte_i;
        end
        if (cmd_done && rx_rw == CMD_READ) begin
            for (int i = 1; i < RES_BUF_LEN; i++) begin
                res_buf[i] <= FILL_BYTE;
            end
            case (rx_op)
                CMD_UPDATE_MTRS, CMD_ENCODER_COUNT: begin
                    // Snapshot of all counts, high byte first
                    for (int j = 0; j < NUM_MOTORS; j++) begin
                        res_buf[2*j+1] <= enc_count_i[j][ENC_COUNT_WIDTH-1 -: SPI_BYTE_WIDTH];
                        res_buf[2*j+2] <= enc_count_i[j][SPI_BYTE_WIDTH-1:0];
                    end
                    res_buf[2*NUM_MOTORS+1] <= wdt_count_i[WDT_COUNT_WIDTH-1 -: SPI_BYTE_WIDTH];
                    res_buf[2*NUM_MOTORS+2] <= wdt_count_i[SPI_BYTE_WIDTH-1:0];
                end
                CMD_DUTY_CYCLE: begin
                    for (int j = 0; j < NUM_MOTORS; j++) begin
                        res_buf[2*j+1] <= spi_byte_t'(duty_o[j][DUTY_WIDTH-1:SPI_BYTE_WIDTH]);
                        res_buf[2*j+2] <= duty_o[j][SPI_BYTE_WIDTH-1:0];
                    end
                end
                default: begin
                    // Fill pattern already loaded
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- host_proto_pkg.sv
// Host SPI protocol definitions with bit 7 of the command byte selecting read and 12 byte frames
`default_nettype none

package host_proto_pkg;

    localparam int SPI_BYTE_WIDTH = 8;

    // Response and request buffers share one length
    localparam int RES_BUF_LEN = 12;

    // Byte counter saturates at the buffer length
    localparam int BYTE_CNT_WIDTH = $clog2(RES_BUF_LEN + 1);

    // Hall health bits carried in the status byte
    localparam int STATUS_HALL_BITS = 4;

    // Pattern for unknown reads, easy to spot on a scope
    localparam logic [SPI_BYTE_WIDTH-1:0] FILL_BYTE = 8'hAA;

    typedef logic [SPI_BYTE_WIDTH-1:0] spi_byte_t;

    typedef enum logic [SPI_BYTE_WIDTH-2:0] {
        CMD_UPDATE_MTRS     = 7'h00,
        CMD_ENCODER_COUNT   = 7'h11,
        CMD_DUTY_CYCLE      = 7'h13,
        CMD_TOGGLE_MOTOR_EN = 7'h30
    } cmd_op_e;

    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_rw_e;

    // First response byte of every transfer
    typedef struct packed {
        logic                        motors_en;
        logic                        wdt_tripped;
        logic [1:0]                  zero;
        logic [STATUS_HALL_BITS-1:0] hall_ok;
    } status_t;

endpackage

`default_nettype wire

//--- list.f
motor_cfg_pkg.sv
host_proto_pkg.sv
pin_sync.sv
spi_byte_slave.sv
host_cmd_engine.sv
motor_watchdog.sv
quad_encoder_counter.sv
bldc_commutator.sv
robocup_top.sv
robocup_tb.sv

//--- motor_cfg_pkg.sv
// Motor constants and types for four wheel motors with hall and encoder bits ordered as named
`default_nettype none

package motor_cfg_pkg;

    // Four wheel motors, one encoder each
    localparam int NUM_MOTORS = 4;

    // Duty cycle resolution sets the PWM frame length in sysclk cycles
    localparam int DUTY_WIDTH = 10;
    localparam int PWM_PERIOD = 1 << DUTY_WIDTH;

    localparam int ENC_COUNT_WIDTH = 16;

    // Watchdog advances once every 4 sysclk
    localparam int WDT_PRESCALE_WIDTH = 2;
    localparam int WDT_COUNT_WIDTH = 16;

    // Hall code reads as {a, b, c}
    typedef struct packed {
        logic a;
        logic b;
        logic c;
    } hall_t;

    typedef struct packed {
        logic a;
        logic b;
    } enc_t;

    // High and low side gate per phase
    typedef struct packed {
        logic ah;
        logic al;
        logic bh;
        logic bl;
        logic ch;
        logic cl;
    } phase_t;

    typedef logic [DUTY_WIDTH-1:0] duty_t;
    typedef logic [ENC_COUNT_WIDTH-1:0] enc_count_t;

endpackage

`default_nettype wire

//--- motor_watchdog.sv
// Motor watchdog that trips after about 4 x 65535 sysclk without a host clear or enable change
`timescale 1ns/1ps
`default_nettype none

module motor_watchdog import motor_cfg_pkg::*; (
    input  wire                        sysclk,
    input  wire                        watchdog_timer_reset_flag,
    input  wire                        clear_i,
    input  wire                        motors_en_i,
    output logic [WDT_COUNT_WIDTH-1:0] count_o,
    output logic                       trip_o
);

    logic [WDT_PRESCALE_WIDTH-1:0] prescale_q;
    logic                          en_q;
    logic                          restart;
    logic                          tick;

    // Any enable toggle counts as host activity
    assign restart = clear_i || (motors_en_i != en_q);
    assign tick    = &prescale_q;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            prescale_q <= '0;
            en_q       <= 1'b0;
            count_o    <= '0;
            trip_o     <= 1'b0;
        end else begin
            en_q   <= motors_en_i;
            trip_o <= 1'b0;
            if (restart) begin
                prescale_q <= '0;
                count_o    <= '0;
            end else begin
                prescale_q <= prescale_q + 1'b1;
                if (tick) begin
                    if (&count_o) begin
                        // Expiry pulse, then a fresh period
                        trip_o  <= 1'b1;
                        count_o <= '0;
                    end else begin
                        count_o <= count_o + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- pin_sync.sv
// Two flop synchronizer for all asynchronous input pins so every output lags its pin by 2 sysclk
`timescale 1ns/1ps
`default_nettype none

module pin_sync import motor_cfg_pkg::*; (
    input  wire                           sysclk,
    input  wire                           watchdog_timer_reset_flag,
    input  wire hall_t [NUM_MOTORS-1:0]   hall_i,
    input  wire enc_t  [NUM_MOTORS-1:0]   enc_i,
    input  wire                           sck_i,
    input  wire                           mosi_i,
    input  wire                           ncs_i,
    output hall_t      [NUM_MOTORS-1:0]   hall_o,
    output enc_t       [NUM_MOTORS-1:0]   enc_o,
    output logic                          sck_o,
    output logic                          mosi_o,
    output logic                          ncs_o
);

    // All pins travel together through both stages
    typedef struct packed {
        hall_t [NUM_MOTORS-1:0] hall;
        enc_t  [NUM_MOTORS-1:0] enc;
        logic                   sck;
        logic                   mosi;
        logic                   ncs;
    } pins_t;

    pins_t pins_in;
    pins_t meta_q;
    pins_t sync_q;

    assign pins_in = {hall_i, enc_i, sck_i, mosi_i, ncs_i};

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            meta_q     <= '0;
            sync_q     <= '0;
            // Chip select idles deselected
            meta_q.ncs <= 1'b1;
            sync_q.ncs <= 1'b1;
        end else begin
            meta_q <= pins_in;
            sync_q <= meta_q;
        end
    end

    assign hall_o = sync_q.hall;
    assign enc_o  = sync_q.enc;
    assign sck_o  = sync_q.sck;
    assign mosi_o = sync_q.mosi;
    assign ncs_o  = sync_q.ncs;

endmodule

`default_nettype wire

//--- quad_encoder_counter.sv
// X4 quadrature counter on synchronized inputs where a two bit jump is dropped without a count
`timescale 1ns/1ps
`default_nettype none

module quad_encoder_counter import motor_cfg_pkg::*; (
    input  wire        sysclk,
    input  wire        watchdog_timer_reset_flag,
    input  wire enc_t  enc_i,
    input  wire        clear_i,
    output enc_count_t count_o
);

    enc_t enc_q;
    logic step;
    logic up;

    // Exactly one of A and B changed
    assign step = (enc_i.a ^ enc_q.a) ^ (enc_i.b ^ enc_q.b);
    // A leading B counts up
    assign up   = enc_i.a ^ enc_q.b;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            // Track the current pins so leaving reset makes no step
            enc_q   <= enc_i;
            count_o <= '0;
        end else begin
            enc_q <= enc_i;
            if (clear_i) begin
                count_o <= '0;
            end else if (step) begin
                // Wraps at 16 bits in both directions
                count_o <= up ? count_o + 1'b1 : count_o - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- robocup_patterns.txt
# T n send[0..n-1] expect[0..n-1] in hex, XX = not checked; E encoder steps; W = watchdog expiry
# H motor hall(abc, binary) phase(ah al bh bl ch cl, binary) over one PWM frame
T 12 93 00 00 00 00 00 00 00 00 00 00 00 0F 00 00 00 00 00 00 00 00 AA AA AA
H 0 101 000000
T 9 80 FF 03 23 01 C4 02 FF 03 0F 00 00 00 00 00 00 00 00
T 12 93 00 00 00 00 00 00 00 00 00 00 00 8F 03 FF 01 23 02 C4 03 FF AA AA AA
H 0 101 100100
H 0 100 100001
H 0 110 001001
H 0 010 011000
H 0 011 010010
H 0 001 000110
H 0 000 000000
T 1 93 8E
H 0 111 000000
T 1 93 8E
H 0 101 100100
H 3 011 010010
E 0 37
E 2 -5
T 12 91 00 00 00 00 00 00 00 00 00 00 00 8F 00 25 00 00 FF FB 00 00 XX XX AA
T 9 80 FF 03 23 01 C4 02 FF 03 8F 00 25 00 00 FF FB 00 00
T 12 91 00 00 00 00 00 00 00 00 00 00 00 8F 00 00 00 00 00 00 00 00 XX XX AA
W
T 1 93 4F
H 0 101 000000
T 2 30 00 4F XX
T 1 93 4F
T 2 B0 00 4F AA
T 1 93 CF
H 0 101 100100
T 12 D5 00 00 00 00 00 00 00 00 00 00 00 CF AA AA AA AA AA AA AA AA AA AA AA

//--- robocup_tb.sv
// Reads robocup_patterns.txt from the project root and each W line waits out a watchdog period
`timescale 1ns/1ps
`default_nettype none

module robocup_tb import motor_cfg_pkg::*, host_proto_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int SCK_HALF     = 10;
    localparam int ENC_HOLD     = 6;
    localparam int HALL_SETTLE  = 8;
    localparam int POLL_GAP     = 1000;
    localparam int LINE_CYCLES  = 3000;
    localparam int WDT_EXPIRY_CYCLES = (1 << WDT_PRESCALE_WIDTH) * (1 << WDT_COUNT_WIDTH);
    localparam     PATTERN_FILE = "robocup_patterns.txt";
    // Low side gates al, bl and cl
    localparam phase_t LOW_SIDES = 6'b010101;

    logic                    sysclk = 1'b0;
    logic                    watchdog_timer_reset_flag;
    hall_t  [NUM_MOTORS-1:0] hall_pins;
    enc_t   [NUM_MOTORS-1:0] enc_pins;
    logic                    spi_sck;
    logic                    spi_mosi;
    logic                    spi_ncs;
    wire                     spi_miso;
    phase_t [NUM_MOTORS-1:0] phase_pins;

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int enc_phase [NUM_MOTORS];
    spi_byte_t tx_bytes [RES_BUF_LEN];
    spi_byte_t rx_bytes [RES_BUF_LEN];
    spi_byte_t exp_bytes [RES_BUF_LEN];
    logic      care [RES_BUF_LEN];

    robocup_top UUT (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .hall_i                    (hall_pins),
        .enc_i                     (enc_pins),
        .spi_sck_i                 (spi_sck),
        .spi_mosi_i                (spi_mosi),
        .spi_ncs_i                 (spi_ncs),
        .phase_o                   (phase_pins),
        .spi_miso_o                (spi_miso)
    );

    // 20 ns period
    always #10 sysclk = ~sysclk;

    // Run limit is one watchdog period plus a budget per pattern line
    always @(posedge sysclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Inputs change 2 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #2;
    endtask

    // Mode 0 host that samples MISO just before each rising sck
    task automatic spi_transfer(input int n);
        spi_byte_t shift_in;
        shift_in = '0;
        spi_ncs = 1'b0;
        for (int k = 0; k < n; k++) begin
            for (int b = SPI_BYTE_WIDTH - 1; b >= 0; b--) begin
                spi_mosi = tx_bytes[k][b];
                wait_cycles(SCK_HALF);
                shift_in = {shift_in[SPI_BYTE_WIDTH-2:0], spi_miso};
                spi_sck = 1'b1;
                wait_cycles(SCK_HALF);
                spi_sck = 1'b0;
            end
            rx_bytes[k] = shift_in;
        end
        wait_cycles(SCK_HALF);
        spi_ncs = 1'b1;
        // Room for the engine to act on chip select release
        wait_cycles(2 * SCK_HALF);
    endtask

    task automatic check_byte(input int pos, input spi_byte_t got, input spi_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t miso byte %0d expected %h got %h", $time, pos, exp, got);
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t status expected %b got %b (en %b/%b tripped %b/%b hall %b/%b)",
                     $time, exp, got, exp.motors_en, got.motors_en,
                     exp.wdt_tripped, got.wdt_tripped, exp.hall_ok, got.hall_ok);
        end
    endtask

    // Over one PWM frame the sink stays on, the source shows up and nothing else does
    task automatic check_phase(input int motor, input phase_t exp);
        phase_t seen_any;
        phase_t seen_all;
        seen_any = '0;
        seen_all = '1;
        for (int c = 0; c < PWM_PERIOD; c++) begin
            seen_any = seen_any | phase_pins[motor];
            seen_all = seen_all & phase_pins[motor];
            wait_cycles(1);
        end
        checks++;
        if (seen_any !== exp || (seen_all & LOW_SIDES) !== (exp & LOW_SIDES)) begin
            errors++;
            $display("[FAIL] %0t phase_o[%0d] expected %b got any %b steady %b",
                     $time, motor, exp, seen_any, seen_all);
        end
    endtask

    // Quadrature states with A a quarter cycle ahead of B
    function automatic enc_t quad_state(input int phase);
        case (phase)
            0: return 2'b00;
            1: return 2'b10;
            2: return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    task automatic step_encoder(input int idx, input int steps);
        int count;
        count = (steps < 0) ? -steps : steps;
        for (int s = 0; s < count; s++) begin
            enc_phase[idx] = (enc_phase[idx] + ((steps < 0) ? 3 : 1)) % 4;
            enc_pins[idx] = quad_state(enc_phase[idx]);
            wait_cycles(ENC_HOLD);
        end
    endtask

    // Poll the status byte with a duty read, which leaves the watchdog running
    task automatic wait_watchdog(output int polls);
        status_t st;
        st = '0;
        polls = 0;
        while (!st.wdt_tripped) begin
            wait_cycles(POLL_GAP);
            tx_bytes[0] = {CMD_READ, CMD_DUTY_CYCLE};
            spi_transfer(1);
            st = rx_bytes[0];
            polls++;
        end
    endtask

    function automatic logic [3:0] hex_value(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return 4'(c - "0");
        end else if (c >= "a" && c <= "f") begin
            return 4'(c - "a" + 10);
        end
        return 4'(c - "A" + 10);
    endfunction

    initial begin
        int fd;
        int r;
        int n;
        int idx;
        int steps;
        int hall_code;
        int phase_code;
        int polls;
        int line_no;
        int pattern_lines;
        int errors_before;
        logic bad_file;
        logic [63:0] kind;
        logic [63:0] tok;
        logic [8*128:1] text;
        line_no = 0;
        pattern_lines = 0;
        bad_file = 1'b0;
        watchdog_timer_reset_flag = 1'b1;
        spi_sck = 1'b0;
        spi_mosi = 1'b0;
        spi_ncs = 1'b1;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            hall_pins[m] = 3'b101;
            enc_pins[m] = 2'b00;
            enc_phase[m] = 0;
        end
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Pattern file %s could not be opened", PATTERN_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(text, fd);
                if (r > 0) begin
                    pattern_lines++;
                end
            end
            $fclose(fd);
            cycle_limit = RESET_CYCLES + NUM_MOTORS * PWM_PERIOD + WDT_EXPIRY_CYCLES
                        + LINE_CYCLES * pattern_lines;
            wait_cycles(RESET_CYCLES);
            watchdog_timer_reset_flag = 1'b0;
            wait_cycles(4);
            // Motors leave reset disabled so every wheel keeps all gates off
            errors_before = errors;
            tests++;
            for (int m = 0; m < NUM_MOTORS; m++) begin
                check_phase(m, '0);
            end
            if (errors != errors_before) begin
                tests_failed++;
            end
            $display("reset phase pins: %s", (errors == errors_before) ? "pass" : "fail");
            fd = $fopen(PATTERN_FILE, "r");
            while (!bad_file && $fscanf(fd, "%s", kind) == 1) begin
                line_no++;
                if (kind == "#") begin
                    r = $fgets(text, fd);
                end else begin
                    errors_before = errors;
                    tests++;
                    if (kind == "T") begin
                        r = $fscanf(fd, "%d", n);
                        for (int k = 0; k < n && k < RES_BUF_LEN; k++) begin
                            r = $fscanf(fd, "%h", tx_bytes[k]);
                        end
                        // XX marks a byte whose value is not checked
                        for (int k = 0; k < n && k < RES_BUF_LEN; k++) begin
                            r = $fscanf(fd, "%s", tok);
                            care[k] = (tok != "XX");
                            exp_bytes[k] = {hex_value(tok[15:8]), hex_value(tok[7:0])};
                        end
                        if (n < 1 || n > RES_BUF_LEN) begin
                            $display("line %0d: transfer length %0d is out of range", line_no, n);
                            errors++;
                            bad_file = 1'b1;
                        end else begin
                            spi_transfer(n);
                            for (int k = 0; k < n; k++) begin
                                if (care[k] && k == 0) begin
                                    check_status(rx_bytes[0], exp_bytes[0]);
                                end else if (care[k]) begin
                                    check_byte(k, rx_bytes[k], exp_bytes[k]);
                                end
                            end
                        end
                    end else if (kind == "E") begin
                        r = $fscanf(fd, "%d %d", idx, steps);
                        step_encoder(idx, steps);
                    end else if (kind == "H") begin
                        r = $fscanf(fd, "%d %b %b", idx, hall_code, phase_code);
                        hall_pins[idx] = hall_t'(hall_code[2:0]);
                        // Two sync flops plus the output register
                        wait_cycles(HALL_SETTLE);
                        check_phase(idx, phase_t'(phase_code[5:0]));
                    end else if (kind == "W") begin
                        wait_watchdog(polls);
                        $display("line %0d: watchdog expired after %0d polls", line_no, polls);
                    end else begin
                        $display("line %0d: unknown pattern kind, reading stopped", line_no);
                        errors++;
                        bad_file = 1'b1;
                    end
                    if (errors != errors_before) begin
                        tests_failed++;
                    end
                    $display("line %0d %s: %s", line_no, kind[7:0],
                             (errors == errors_before) ? "pass" : "fail");
                end
            end
            $fclose(fd);
            if (tests == 0) begin
                $display("No test lines found in %s", PATTERN_FILE);
                errors++;
            end
        end
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- robocup_top.sv
// Motor FPGA top for four wheel motors where inputs lag pins by 2 sysclk and outputs are registered
`timescale 1ns/1ps
`default_nettype none

module robocup_top import motor_cfg_pkg::*, host_proto_pkg::*; (
    input  wire                         sysclk,
    input  wire                         watchdog_timer_reset_flag,
    input  wire hall_t [NUM_MOTORS-1:0] hall_i,
    input  wire enc_t  [NUM_MOTORS-1:0] enc_i,
    input  wire                         spi_sck_i,
    input  wire                         spi_mosi_i,
    input  wire                         spi_ncs_i,
    output phase_t     [NUM_MOTORS-1:0] phase_o,
    output wire                         spi_miso_o
);

    hall_t      [NUM_MOTORS-1:0] hall_s;
    enc_t       [NUM_MOTORS-1:0] enc_s;
    logic                        sck_s;
    logic                        mosi_s;
    logic                        ncs_s;
    spi_byte_t                   rx_byte;
    spi_byte_t                   tx_byte;
    logic                        byte_done;
    logic                        spi_start;
    logic                        spi_end;
    logic                        miso_c;
    logic                        miso_q;
    enc_count_t [NUM_MOTORS-1:0] enc_count;
    duty_t      [NUM_MOTORS-1:0] duty;
    logic                        motors_en;
    logic                        clear;
    logic [WDT_COUNT_WIDTH-1:0]  wdt_count;
    logic                        wdt_trip;
    logic       [NUM_MOTORS-1:0] hall_ok;
    phase_t     [NUM_MOTORS-1:0] phase_c;

    pin_sync u_pin_sync (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .hall_i (hall_i), .enc_i (enc_i),
        .sck_i (spi_sck_i), .mosi_i (spi_mosi_i), .ncs_i (spi_ncs_i),
        .hall_o (hall_s), .enc_o (enc_s),
        .sck_o (sck_s), .mosi_o (mosi_s), .ncs_o (ncs_s)
    );

    spi_byte_slave u_spi_slave (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .sck_i (sck_s), .mosi_i (mosi_s), .ncs_i (ncs_s),
        .tx_byte_i (tx_byte), .rx_byte_o (rx_byte), .byte_done_o (byte_done),
        .start_o (spi_start), .end_o (spi_end), .miso_o (miso_c)
    );

    host_cmd_engine u_cmd_engine (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .rx_byte_i (rx_byte), .byte_done_i (byte_done),
        .start_i (spi_start), .end_i (spi_end),
        .enc_count_i (enc_count), .wdt_count_i (wdt_count),
        .wdt_trip_i (wdt_trip), .hall_ok_i (hall_ok),
        .tx_byte_o (tx_byte), .duty_o (duty),
        .motors_en_o (motors_en), .clear_o (clear)
    );

    motor_watchdog u_watchdog (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .clear_i (clear), .motors_en_i (motors_en),
        .count_o (wdt_count), .trip_o (wdt_trip)
    );

    // One encoder and one commutator per wheel
    for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_motor
        quad_encoder_counter u_enc (
            .sysclk                    (sysclk),
            .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
            .enc_i (enc_s[m]), .clear_i (clear), .count_o (enc_count[m])
        );
        bldc_commutator u_bldc (
            .sysclk                    (sysclk),
            .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
            .hall_i (hall_s[m]), .duty_i (duty[m]), .en_i (motors_en),
            .phase_o (phase_c[m]), .hall_ok_o (hall_ok[m])
        );
    end

    // Output pin registers
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            phase_o <= '0;
            miso_q  <= 1'b0;
        end else begin
            phase_o <= phase_c;
            miso_q  <= miso_c;
        end
    end

    // MISO is only driven while selected
    assign spi_miso_o = ncs_s ? 1'bz : miso_q;

endmodule

`default_nettype wire

//--- spi_byte_slave.sv
// Mode 0 SPI slave byte shifter on synchronized pins that needs an sck half period of 8 sysclk
`timescale 1ns/1ps
`default_nettype none

module spi_byte_slave import host_proto_pkg::*; (
    input  wire            sysclk,
    input  wire            watchdog_timer_reset_flag,
    input  wire            sck_i,
    input  wire            mosi_i,
    input  wire            ncs_i,
    input  wire spi_byte_t tx_byte_i,
    output spi_byte_t      rx_byte_o,
    output logic           byte_done_o,
    output logic           start_o,
    output logic           end_o,
    output logic           miso_o
);

    logic                          sck_q;
    logic                          ncs_q;
    logic [$clog2(SPI_BYTE_WIDTH)-1:0] bit_cnt;
    logic                          reload_q;
    spi_byte_t                     rx_sr;
    spi_byte_t                     tx_sr;
    logic                          sck_rise;
    logic                          sck_fall;

    // Edges from one cycle delayed copies
    assign sck_rise = ~ncs_i & sck_i & ~sck_q;
    assign sck_fall = ~ncs_i & ~sck_i & sck_q;
    assign start_o  = ncs_q & ~ncs_i;
    assign end_o    = ~ncs_q & ncs_i;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            sck_q       <= 1'b0;
            ncs_q       <= 1'b1;
            bit_cnt     <= '0;
            byte_done_o <= 1'b0;
            reload_q    <= 1'b0;
        end else begin
            sck_q       <= sck_i;
            ncs_q       <= ncs_i;
            byte_done_o <= 1'b0;
            // Engine advances its byte counter on byte_done, so reload one cycle later
            reload_q    <= byte_done_o;
            if (start_o) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (&bit_cnt) begin
                    byte_done_o <= 1'b1;
                end
            end
        end
    end

    // Shift registers carry data only
    always_ff @(posedge sysclk) begin
        if (sck_rise) begin
            rx_sr <= {rx_sr[SPI_BYTE_WIDTH-2:0], mosi_i};
        end
        if (start_o || reload_q) begin
            tx_sr <= tx_byte_i;
        end else if (sck_fall && bit_cnt != '0) begin
            // The fall after the last bit keeps the freshly loaded MSB on the line
            tx_sr <= {tx_sr[SPI_BYTE_WIDTH-2:0], 1'b0};
        end
    end

    // Receive register holds the full byte until the next rising sck
    assign rx_byte_o = rx_sr;
    assign miso_o    = tx_sr[SPI_BYTE_WIDTH-1];

endmodule

`default_nettype wire
